// ==== build.f ====
+incdir+design
design/debug_unit_pkg.sv
design/instr_loader.sv
design/latch_dumper.sv
design/debug_ctrl.sv
design/debug_unit.sv
verif/tb_clock.sv
verif/debug_unit_sva.sv
verif/debug_unit_tb.sv

// ==== design/debug_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_config.svh"

module debug_ctrl
    import debug_unit_pkg::*;
(
    input  wire         clk,
    input  wire         i_rst_n,
    input  wire byte_t  i_rx,
    input  wire         i_rx_done,
    input  wire         i_end,
    input  wire         i_halt,
    input  wire         i_dump_done,
    output logic        o_load_en,
    output logic        o_dump_start,
    output logic        o_step,
    output logic        o_start
);

    ctrl_state_e    state_q;
    ctrl_state_e    state_d;
    cmd_e           rx_cmd;
    logic           debug_q;                    // Set while in a debug session
    logic           debug_d;
    logic           step_d;
    logic           dump_start_d;

    assign rx_cmd = cmd_e'(i_rx);

    always_comb begin
        state_d      = state_q;
        debug_d      = debug_q;
        step_d       = 1'b0;
        dump_start_d = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (i_rx_done) begin
                    case (rx_cmd)
                        CMD_LOAD: begin
                            state_d = ST_LOAD;
                        end
                        CMD_DEBUG: begin
                            state_d = ST_DEBUG;
                            debug_d = 1'b1;
                        end
                        CMD_RUN: begin
                            state_d = ST_RUN;
                            debug_d = 1'b0;
                            step_d  = 1'b1;     // Pipeline runs from the next cycle
                        end
                        default: begin
                            state_d = ST_IDLE;  // Unknown byte ignored
                        end
                    endcase
                end
            end
            ST_LOAD: begin
                // Bytes here are instruction data, not commands
                if (i_halt) begin
                    state_d = ST_IDLE;
                end
            end
            ST_DEBUG: begin
                if (i_rx_done) begin
                    case (rx_cmd)
                        CMD_STEP: begin
                            state_d      = ST_DUMP;
                            step_d       = 1'b1;
                            dump_start_d = 1'b1;
                        end
                        CMD_END: begin
                            state_d      = ST_DUMP;
                            debug_d      = 1'b0;
                            dump_start_d = 1'b1;    // Final dump, then idle
                        end
                        default: begin
                            state_d = ST_DEBUG;
                        end
                    endcase
                end
            end
            ST_RUN: begin
                if (i_end) begin
                    state_d      = ST_DUMP;
                    dump_start_d = 1'b1;
                end else begin
                    step_d = 1'b1;
                end
            end
            ST_DUMP: begin
                if (i_dump_done) begin
                    state_d = debug_q ? ST_DEBUG : ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= ST_IDLE;
            debug_q      <= 1'b0;
            o_step       <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            state_q      <= state_d;
            debug_q      <= debug_d;
            o_step       <= step_d;
            o_dump_start <= dump_start_d;
        end
    end

    assign o_load_en = (state_q == ST_LOAD);
    // Every dump is entered from run or debug
    assign o_start   = (state_q == ST_RUN) || (state_q == ST_DEBUG) || (state_q == ST_DUMP);

endmodule

`default_nettype wire

// ==== design/debug_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_config.svh"

module debug_unit
    import debug_unit_pkg::*;
(
    input  wire                         clk,
    input  wire                         i_rst_n,

    // UART receiver
    input  wire byte_t                  i_rx,
    input  wire                         i_rx_done,

    // UART transmitter
    output wire                         o_tx_start,
    output byte_t                       o_tx_data,
    input  wire                         i_tx_done,

    // Pipeline
    input  wire                         i_end,
    input  wire [`DU_ID_EX_W-1:0]       i_id_ex,
    input  wire [`DU_EX_MEM_W-1:0]      i_ex_mem,
    input  wire [`DU_MEM_WB_W-1:0]      i_mem_wb,
    input  wire [`DU_WB_ID_W-1:0]       i_wb_id,
    input  wire [`DU_CONTROL_W-1:0]     i_control,
    output word_t                       o_instr,
    output word_t                       o_instr_addr,
    output wire                         o_instr_valid,
    output wire                         o_step,
    output wire                         o_start
);

    wire load_en;                               // Controller in load mode
    wire halt;                                  // Halt word written
    wire dump_start;
    wire dump_done;

    debug_ctrl u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_rx           (i_rx),
        .i_rx_done      (i_rx_done),
        .i_end          (i_end),
        .i_halt         (halt),
        .i_dump_done    (dump_done),
        .o_load_en      (load_en),
        .o_dump_start   (dump_start),
        .o_step         (o_step),
        .o_start        (o_start)
    );

    instr_loader u_loader (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_load_en      (load_en),
        .i_rx           (i_rx),
        .i_rx_done      (i_rx_done),
        .o_instr        (o_instr),
        .o_instr_addr   (o_instr_addr),
        .o_instr_valid  (o_instr_valid),
        .o_halt         (halt)
    );

    latch_dumper u_dumper (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_dump_start   (dump_start),
        .i_id_ex        (i_id_ex),
        .i_ex_mem       (i_ex_mem),
        .i_mem_wb       (i_mem_wb),
        .i_wb_id        (i_wb_id),
        .i_control      (i_control),
        .i_tx_done      (i_tx_done),
        .o_tx_start     (o_tx_start),
        .o_tx_data      (o_tx_data),
        .o_dump_done    (dump_done)
    );

endmodule

`default_nettype wire

// ==== design/debug_unit_config.svh ====
`ifndef DEBUG_UNIT_CONFIG_SVH
`define DEBUG_UNIT_CONFIG_SVH

// UART byte and processor word
`define DU_BYTE_W       8
`define DU_WORD_W       32

// Instruction loading
`define DU_ADDR_STEP    4                   // Byte address step per word
`define DU_WORD_BYTES   4                   // Bytes per instruction, MSB first
`define DU_HALT_WORD    32'hFFFF_FFFF       // Last word of a program

// Pipeline latch groups, in dump order
`define DU_ID_EX_W      144
`define DU_EX_MEM_W     32
`define DU_MEM_WB_W     48
`define DU_WB_ID_W      40
`define DU_CONTROL_W    24

// Whole snapshot
`define DU_DUMP_W       (`DU_ID_EX_W + `DU_EX_MEM_W + `DU_MEM_WB_W + `DU_WB_ID_W + `DU_CONTROL_W)
`define DU_DUMP_BYTES   36                  // DU_DUMP_W / DU_BYTE_W

`endif

// ==== design/debug_unit_pkg.sv ====
`default_nettype none

`include "debug_unit_config.svh"

package debug_unit_pkg;

    typedef logic [`DU_BYTE_W-1:0] byte_t;      // One UART byte
    typedef logic [`DU_WORD_W-1:0] word_t;      // Instruction or address
    typedef logic [`DU_DUMP_W-1:0] dump_t;      // ID_EX in the MSBs, CONTROL in the LSBs

    // Host command bytes, one-hot
    typedef enum logic [7:0] {
        CMD_LOAD  = 8'h01,
        CMD_DEBUG = 8'h02,
        CMD_RUN   = 8'h04,
        CMD_STEP  = 8'h08,
        CMD_END   = 8'h10
    } cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,                                // Waiting for load, debug or run
        ST_LOAD,                                // Bytes go to the loader
        ST_DEBUG,                               // Waiting for step or end
        ST_RUN,                                 // Free running until i_end
        ST_DUMP                                 // Latch dump in progress
    } ctrl_state_e;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_SEND,                                // Start pulse for one byte
        DS_WAIT                                 // Waiting for transmitter done
    } dump_state_e;

endpackage

`default_nettype wire

// ==== design/instr_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_config.svh"

module instr_loader
    import debug_unit_pkg::*;
(
    input  wire         clk,
    input  wire         i_rst_n,
    input  wire         i_load_en,
    input  wire byte_t  i_rx,
    input  wire         i_rx_done,
    output word_t       o_instr,
    output word_t       o_instr_addr,
    output logic        o_instr_valid,
    output logic        o_halt
);

    localparam int CNT_W = $clog2(`DU_WORD_BYTES);

    logic [CNT_W-1:0] byte_cnt;
    word_t            word_q;
    word_t            word_next;
    word_t            addr_q;
    logic             byte_in;
    logic             last_byte;

    assign byte_in   = i_load_en && i_rx_done;
    assign last_byte = byte_in && (byte_cnt == CNT_W'(`DU_WORD_BYTES - 1));

    // New byte enters at the bottom, so the first byte ends up as MSB
    assign word_next = {word_q[`DU_WORD_W-`DU_BYTE_W-1:0], i_rx};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt <= '0;
        end else if (!i_load_en) begin
            byte_cnt <= '0;                     // Realign on every new load
        end else if (byte_in) begin
            byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_in) begin
            word_q <= word_next;
        end
    end

    // Strobe and halt flag line up with the completed word
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_instr_valid <= 1'b0;
            o_halt        <= 1'b0;
        end else begin
            o_instr_valid <= last_byte;
            o_halt        <= last_byte && (word_next == `DU_HALT_WORD);
        end
    end

    // Address moves on after the strobe cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= '0;
        end else if (!i_load_en) begin
            addr_q <= '0;
        end else if (o_instr_valid) begin
            addr_q <= addr_q + word_t'(`DU_ADDR_STEP);
        end
    end

    assign o_instr      = word_q;
    assign o_instr_addr = addr_q;

endmodule

`default_nettype wire

// ==== design/latch_dumper.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_config.svh"

module latch_dumper
    import debug_unit_pkg::*;
(
    input  wire                         clk,
    input  wire                         i_rst_n,
    input  wire                         i_dump_start,
    input  wire [`DU_ID_EX_W-1:0]       i_id_ex,
    input  wire [`DU_EX_MEM_W-1:0]      i_ex_mem,
    input  wire [`DU_MEM_WB_W-1:0]      i_mem_wb,
    input  wire [`DU_WB_ID_W-1:0]       i_wb_id,
    input  wire [`DU_CONTROL_W-1:0]     i_control,
    input  wire                         i_tx_done,
    output logic                        o_tx_start,
    output byte_t                       o_tx_data,
    output logic                        o_dump_done
);

    localparam int IDX_W = $clog2(`DU_DUMP_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`DU_DUMP_BYTES - 1);

    dump_state_e        state_q;
    logic [IDX_W-1:0]   idx_q;
    dump_t              snap_q;
    logic               capture;
    logic               byte_sent;

    assign capture   = (state_q == DS_IDLE) && i_dump_start;
    assign byte_sent = (state_q == DS_WAIT) && i_tx_done;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= DS_IDLE;
            idx_q       <= '0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;
            case (state_q)
                DS_IDLE: begin
                    if (i_dump_start) begin
                        state_q <= DS_SEND;
                        idx_q   <= '0;
                    end
                end
                DS_SEND: begin
                    state_q <= DS_WAIT;         // Start pulse lasts one cycle
                end
                DS_WAIT: begin
                    if (i_tx_done) begin
                        if (idx_q == LAST_IDX) begin
                            state_q     <= DS_IDLE;
                            o_dump_done <= 1'b1;
                        end else begin
                            state_q <= DS_SEND;
                            idx_q   <= idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= DS_IDLE;
                end
            endcase
        end
    end

    // All five groups are sampled in the same cycle, so the dump is coherent.
    // After each byte the snapshot shifts up and the next byte sits on top.
    always_ff @(posedge clk) begin
        if (capture) begin
            snap_q <= {i_id_ex, i_ex_mem, i_mem_wb, i_wb_id, i_control};
        end else if (byte_sent) begin
            snap_q <= snap_q << `DU_BYTE_W;
        end
    end

    assign o_tx_start = (state_q == DS_SEND);
    assign o_tx_data  = snap_q[`DU_DUMP_W-1 -: `DU_BYTE_W];

endmodule

`default_nettype wire

// ==== verif/debug_unit_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_unit_sva (
    input wire clk,
    input wire i_rst_n,
    input wire i_step,
    input wire i_debug,
    input wire i_tx_start,
    input wire i_tx_done,
    input wire i_instr_valid
);

    logic tx_busy;                              // Byte handed over, done not yet back
    int   fail_cnt = 0;                         // Number of assertion failures so far

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_busy <= 1'b0;
        end else if (i_tx_start) begin
            tx_busy <= 1'b1;
        end else if (i_tx_done) begin
            tx_busy <= 1'b0;
        end
    end

    step_single_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_step && i_debug) |=> !i_step)
        else begin
            $error("step held longer than one cycle in debug mode");
            fail_cnt++;
        end

    tx_start_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx_start |-> !tx_busy)
        else begin
            $error("transmit start issued before the previous byte was done");
            fail_cnt++;
        end

    strobe_not_during_tx: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_instr_valid && i_tx_start))
        else begin
            $error("instruction write strobe while a byte is being sent");
            fail_cnt++;
        end

endmodule

bind debug_unit debug_unit_sva u_sva (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_step         (o_step),
    .i_debug        (u_ctrl.debug_q),
    .i_tx_start     (o_tx_start),
    .i_tx_done      (i_tx_done),
    .i_instr_valid  (o_instr_valid)
);

`default_nettype wire

// ==== verif/debug_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "debug_unit_config.svh"

module debug_unit_tb
    import debug_unit_pkg::*;
();

    localparam int NUM_DUMPS   = 6;
    localparam int TX_STRETCH  = 20;            // Extra done delay in the slow test
    localparam int BYTE_CYCLES = 6 + TX_STRETCH;
    localparam int CYCLE_LIMIT = NUM_DUMPS * `DU_DUMP_BYTES * BYTE_CYCLES + 2000;

    logic                       clk;
    logic                       rst_n;
    byte_t                      rx_byte;
    logic                       rx_done;
    logic                       tx_start;
    byte_t                      tx_data;
    logic                       tx_done;
    logic                       pipe_end;
    logic [`DU_ID_EX_W-1:0]     id_ex;
    logic [`DU_EX_MEM_W-1:0]    ex_mem;
    logic [`DU_MEM_WB_W-1:0]    mem_wb;
    logic [`DU_WB_ID_W-1:0]     wb_id;
    logic [`DU_CONTROL_W-1:0]   control;
    word_t                      instr;
    word_t                      instr_addr;
    logic                       instr_valid;
    logic                       step;
    logic                       start;

    word_t      lfsr_state = 32'd95719;
    dump_t      latch_val;                      // Current latch inputs, ID_EX on top
    byte_t      tx_bytes[$];                    // Bytes seen by the transmitter model
    int         tx_stretch = 0;
    int         strobe_count = 0;
    int         errors = 0;
    int         tests = 0;
    int         cycle_cnt = 0;

    tb_clock u_clock (.o_clk(clk));

    debug_unit UUT (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_rx           (rx_byte),
        .i_rx_done      (rx_done),
        .o_tx_start     (tx_start),
        .o_tx_data      (tx_data),
        .i_tx_done      (tx_done),
        .i_end          (pipe_end),
        .i_id_ex        (id_ex),
        .i_ex_mem       (ex_mem),
        .i_mem_wb       (mem_wb),
        .i_wb_id        (wb_id),
        .i_control      (control),
        .o_instr        (instr),
        .o_instr_addr   (instr_addr),
        .o_instr_valid  (instr_valid),
        .o_step         (step),
        .o_start        (start)
    );

    // Galois LFSR, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[`DU_WORD_W-2:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic fill_latches();
        dump_t v;
        v = '0;
        for (int i = 0; i < `DU_DUMP_W / 16; i++) begin
            v = (v << 16) | dump_t'(rand_bits(16));
        end
        latch_val = v;
        {id_ex, ex_mem, mem_wb, wb_id, control} = v;
    endtask

    task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One-cycle receive pulse, returns in the following cycle
    task automatic send_rx(input byte_t b);
        rx_byte = b;
        rx_done = 1'b1;
        @(posedge clk);
        #1;
        rx_done = 1'b0;
    endtask

    task automatic check_step_start(input logic exp_step, input logic exp_start,
                                    input string what);
        @(negedge clk);
        compare_bit(step, exp_step, {what, ": step"});
        compare_bit(start, exp_start, {what, ": start"});
        @(posedge clk);
        #1;
    endtask

    task automatic send_word(input word_t w, input word_t addr);
        for (int i = 0; i < `DU_WORD_BYTES; i++) begin
            send_rx(w[`DU_WORD_W-1-i*`DU_BYTE_W -: `DU_BYTE_W]);
            if (i < `DU_WORD_BYTES - 1) begin
                wait_cycles(1);
            end
        end
        @(negedge clk);                         // Strobe cycle
        compare_bit(instr_valid, 1'b1, "write strobe");
        compare_word(instr, w, "instruction");
        compare_word(instr_addr, addr, "instruction address");
        @(posedge clk);
        #1;
    endtask

    // Inputs change once the dump runs, the bytes must still match the snapshot
    task automatic check_dump(input dump_t exp, input string what, output int cycles);
        cycles = 0;
        while (tx_bytes.size() == 0) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        fill_latches();
        while (!UUT.dump_done) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (tx_bytes.size() != `DU_DUMP_BYTES) begin
            $display("%s: dump sent %0d bytes instead of %0d", what, tx_bytes.size(),
                     `DU_DUMP_BYTES);
            errors++;
        end else begin
            for (int i = 0; i < `DU_DUMP_BYTES; i++) begin
                compare_byte(tx_bytes[i], exp[`DU_DUMP_W-1-i*`DU_BYTE_W -: `DU_BYTE_W],
                             $sformatf("%s byte %0d", what, i));
            end
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        $display("%s: %s, %0d errors", name, (errors == err0) ? "passed" : "FAILED",
                 errors - err0);
    endtask

    task automatic idle_after_reset();
        int err0;
        err0 = errors;
        @(negedge clk);
        compare_bit(step, 1'b0, "step after reset");
        compare_bit(start, 1'b0, "start after reset");
        compare_bit(instr_valid, 1'b0, "write strobe after reset");
        compare_bit(tx_start, 1'b0, "transmit start after reset");
        @(posedge clk);
        #1;
        send_rx(8'h55);                         // Not a command
        repeat (4) check_step_start(1'b0, 1'b0, "idle after unknown byte");
        if (strobe_count != 0 || tx_bytes.size() != 0) begin
            $display("Unknown byte in idle caused a write or a transmit");
            errors++;
        end
        finish_test("idle_after_reset", err0);
    endtask

    task automatic load_program();
        int    err0;
        word_t words[4];
        err0 = errors;
        strobe_count = 0;
        for (int i = 0; i < 3; i++) begin
            words[i] = rand_bits(32);
        end
        words[3] = `DU_HALT_WORD;
        send_rx(CMD_LOAD);
        for (int i = 0; i < 4; i++) begin
            send_word(words[i], word_t'(i * `DU_ADDR_STEP));
        end
        wait_cycles(2);
        // Second load must begin at address zero again
        send_rx(CMD_LOAD);
        send_word(rand_bits(32), word_t'(0));
        send_word(`DU_HALT_WORD, word_t'(`DU_ADDR_STEP));
        wait_cycles(2);
        if (strobe_count != 6) begin
            $display("Load wrote %0d words instead of 6", strobe_count);
            errors++;
        end
        finish_test("load_program", err0);
    endtask

    task automatic run_to_end();
        int    err0;
        int    cycles;
        dump_t snap;
        err0 = errors;
        fill_latches();
        snap = latch_val;
        tx_bytes.delete();
        send_rx(CMD_RUN);
        repeat (5) check_step_start(1'b1, 1'b1, "running");
        pipe_end = 1'b1;
        check_step_start(1'b1, 1'b1, "end raised");
        check_step_start(1'b0, 1'b1, "end seen");
        check_dump(snap, "run dump", cycles);
        wait_cycles(1);
        pipe_end = 1'b0;
        check_step_start(1'b0, 1'b0, "after run dump");
        finish_test("run_to_end", err0);
    endtask

    task automatic debug_steps();
        int    err0;
        int    cycles;
        dump_t snap;
        err0 = errors;
        send_rx(CMD_DEBUG);
        check_step_start(1'b0, 1'b1, "debug entry");
        for (int n = 0; n < 2; n++) begin
            fill_latches();
            snap = latch_val;
            tx_bytes.delete();
            send_rx(CMD_STEP);
            check_step_start(1'b1, 1'b1, "step pulse");
            check_step_start(1'b0, 1'b1, "after step pulse");
            check_dump(snap, $sformatf("step %0d dump", n), cycles);
            wait_cycles(1);
            check_step_start(1'b0, 1'b1, "back in debug");
        end
        finish_test("debug_steps", err0);
    endtask

    task automatic debug_end();
        int    err0;
        int    cycles;
        dump_t snap;
        err0 = errors;
        fill_latches();
        snap = latch_val;
        tx_bytes.delete();
        send_rx(CMD_END);
        check_step_start(1'b0, 1'b1, "end accepted");
        check_dump(snap, "final dump", cycles);
        wait_cycles(1);
        check_step_start(1'b0, 1'b0, "idle after end");
        finish_test("debug_end", err0);
    endtask

    task automatic slow_transmitter();
        int    err0;
        int    cycles;
        dump_t snap;
        err0 = errors;
        tx_stretch = TX_STRETCH;
        send_rx(CMD_DEBUG);
        check_step_start(1'b0, 1'b1, "slow debug entry");
        fill_latches();
        snap = latch_val;
        tx_bytes.delete();
        send_rx(CMD_STEP);
        check_step_start(1'b1, 1'b1, "slow step pulse");
        check_dump(snap, "slow step dump", cycles);
        if (cycles < `DU_DUMP_BYTES * TX_STRETCH) begin
            $display("Dump took only %0d cycles with a slow transmitter", cycles);
            errors++;
        end
        wait_cycles(1);
        fill_latches();
        snap = latch_val;
        tx_bytes.delete();
        send_rx(CMD_END);
        check_dump(snap, "slow final dump", cycles);
        wait_cycles(1);
        check_step_start(1'b0, 1'b0, "idle after slow dump");
        tx_stretch = 0;
        finish_test("slow_transmitter", err0);
    endtask

    // Transmitter model, done comes back a few cycles after each start
    initial begin : tx_model
        int gap;
        tx_done = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_start) begin
                tx_bytes.push_back(tx_data);
                gap = 1 + int'(rand_bits(2)) + tx_stretch;
                repeat (gap) @(posedge clk);
                #1;
                tx_done = 1'b1;
                @(posedge clk);
                #1;
                tx_done = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (instr_valid) begin
            strobe_count++;
        end
    end

    initial begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the run did not finish", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        rx_byte  = '0;
        rx_done  = 1'b0;
        pipe_end = 1'b0;
        fill_latches();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_after_reset();
        load_program();
        run_to_end();
        debug_steps();
        debug_end();
        slow_transmitter();
        errors += UUT.u_sva.fail_cnt;
        $display("Tests: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic o_clk
);

    localparam int HALF_PERIOD = 5;             // 10 ns clock

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire
